//--- flist.f
rtl/rx_pkg.sv
rtl/buffer_pkg.sv
rtl/capture_bank.sv
rtl/capture_control.sv
rtl/readout_control.sv
rtl/stream_reg.sv
rtl/adc_buffer.sv
testbench/adc_buffer_tb.sv

//--- Makefile
SIM     := verilator
TOP     := adc_buffer_tb
FLIST   := flist.f
FLAGS   := --binary --timing -j 0
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/adc_buffer_tb.sv
/*
 * Testbench for adc_buffer with BUFFER_DEPTH 16 and a model of banking, fill and readout.
 * Slots not written by the current capture are not compared on readout.
 */
`timescale 1ns/1ps
`default_nettype none

module adc_buffer_tb;

  import rx_pkg::*;
  import buffer_pkg::*;

  localparam int SEED = 32'h4dded4be;
  localparam int COUNT_W = $clog2(BUFFER_DEPTH);
  localparam int WORDS = CHANNELS * BUFFER_DEPTH;
  localparam int CAPTURE_TIMEOUT = 4000;
  localparam int WAIT_TIMEOUT = 200;
  localparam int START_REFUSE_CYCLES = 50;
  localparam int NUM_TESTS = 7;

  typedef enum int {
    NO_ABORT,
    ABORT_CAPTURE,
    ABORT_READOUT
  } abort_t;

  typedef struct {
    banking_mode_t mode;
    int            valid_pct;
    bit            backpressure;
    int            depth_hold;
    abort_t        abort_kind;
  } test_row_t;

  // mode, valid %, readout back-pressure, report hold cycles, abort
  test_row_t rows [NUM_TESTS] = '{
    '{2'd0, 100, 1'b0, 0, NO_ABORT},
    '{2'd1, 70, 1'b1, 3, NO_ABORT},
    '{2'd2, 50, 1'b1, 8, NO_ABORT},
    '{2'd3, 80, 1'b0, 1, NO_ABORT},
    '{2'd1, 60, 1'b1, 5, ABORT_CAPTURE},
    '{2'd2, 90, 1'b1, 2, ABORT_READOUT},
    '{2'd0, 40, 1'b1, 12, NO_ABORT}
  };

  logic          adc_clk;
  logic          reset;
  adc_data_t     adc_data;
  logic          cap_cmd_valid;
  cap_cmd_t      cap_cmd;
  logic          cap_cmd_ready;
  logic          ro_cmd_valid;
  ro_op_t        ro_cmd;
  logic          ro_cmd_ready;
  logic          write_depth_valid;
  write_depth_t  write_depth;
  logic          write_depth_ready;
  logic          readout_valid;
  readout_word_t readout;
  logic          readout_ready;

  // reference model state
  sample_t exp_mem [CHANNELS][BUFFER_DEPTH];
  bit      exp_written [CHANNELS][BUFFER_DEPTH];
  int      sent [CHANNELS];
  int      active;
  bit      model_armed;

  int errors;
  int tests_passed;
  int tests_failed;
  bit timed_out;

  adc_buffer #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) UUT (
    .adc_clk(adc_clk),
    .reset_i(reset),
    .adc_data_i(adc_data),
    .cap_cmd_valid_i(cap_cmd_valid),
    .cap_cmd_i(cap_cmd),
    .cap_cmd_ready_o(cap_cmd_ready),
    .ro_cmd_valid_i(ro_cmd_valid),
    .ro_cmd_i(ro_cmd),
    .ro_cmd_ready_o(ro_cmd_ready),
    .write_depth_valid_o(write_depth_valid),
    .write_depth_o(write_depth),
    .write_depth_ready_i(write_depth_ready),
    .readout_valid_o(readout_valid),
    .readout_o(readout),
    .readout_ready_i(readout_ready)
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_depth(input write_depth_t got, input write_depth_t want,
                             input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic check_word(input readout_word_t got, input readout_word_t want,
                            input bit data_known, input string what);
    if (got.last !== want.last || (data_known && got.data !== want.data)) begin
      $display("CHECK FAILED at %0t ns: %s, got %h/%b expected %h/%b", $time, what,
               got.data, got.last, want.data, want.last);
      errors++;
    end
  endtask

  task automatic check_ready(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    timed_out = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic void reset_model(input banking_mode_t mode);
    active = 1 << ((mode == 2'd3) ? 2 : int'(mode));
    model_armed = 1'b1;
    for (int c = 0; c < CHANNELS; c++) begin
      sent[c] = 0;
      for (int s = 0; s < BUFFER_DEPTH; s++) begin
        exp_written[c][s] = 1'b0;
      end
    end
  endfunction

  // one cycle of samples as the DUT sees them on the next edge
  function automatic void model_capture(input adc_data_t d);
    int bank;
    int slot;
    bit stop;
    stop = 1'b0;
    for (int c = 0; c < active && model_armed; c++) begin
      if (d.valid[c]) begin
        bank = c + active * (sent[c] / BUFFER_DEPTH);
        slot = sent[c] % BUFFER_DEPTH;
        exp_mem[bank][slot] = d.data[c];
        exp_written[bank][slot] = 1'b1;
        sent[c]++;
        stop |= sent[c] == BUFFER_DEPTH * (CHANNELS / active);
      end
    end
    if (stop) begin
      model_armed = 1'b0;
    end
  endfunction

  function automatic write_depth_t expected_depth();
    write_depth_t want;
    int n;
    for (int b = 0; b < CHANNELS; b++) begin
      // banks of a channel fill in order, later ones get what is left
      n = sent[b % active] - (b / active) * BUFFER_DEPTH;
      n = (n < 0) ? 0 : ((n > BUFFER_DEPTH) ? BUFFER_DEPTH : n);
      want[b].full = n == BUFFER_DEPTH;
      want[b].count = COUNT_W'(n % BUFFER_DEPTH);
    end
    return want;
  endfunction

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic drive_samples(input int valid_pct);
    adc_data_t d;
    for (int c = 0; c < CHANNELS; c++) begin
      d.valid[c] = $urandom_range(99, 0) < valid_pct;
      d.data[c] = sample_t'($urandom);
    end
    adc_data = d;
    model_capture(d);
  endtask

  task automatic send_cap_cmd(input cap_op_t op, input banking_mode_t mode);
    int waited;
    waited = 0;
    cap_cmd_valid = 1'b1;
    cap_cmd = '{op: op, mode: mode};
    @(negedge adc_clk);
    while (!cap_cmd_ready && waited < WAIT_TIMEOUT) begin
      next_cycle();
      @(negedge adc_clk);
      waited++;
    end
    if (!cap_cmd_ready) begin
      report_timeout("capture command was never accepted");
    end
    next_cycle();
    cap_cmd_valid = 1'b0;
  endtask

  task automatic send_ro_cmd(input ro_op_t op);
    int waited;
    waited = 0;
    ro_cmd_valid = 1'b1;
    ro_cmd = op;
    @(negedge adc_clk);
    if (op == START) begin
      check_ready(ro_cmd_ready, 1'b1, "START accepted once capture is done");
    end
    while (!ro_cmd_ready && waited < WAIT_TIMEOUT) begin
      next_cycle();
      @(negedge adc_clk);
      waited++;
    end
    if (!ro_cmd_ready) begin
      report_timeout("readout command was never accepted");
    end
    next_cycle();
    ro_cmd_valid = 1'b0;
  endtask

  task automatic arm_capture(input banking_mode_t mode);
    send_cap_cmd(ARM, mode);
    reset_model(mode);
  endtask

  task automatic check_start_refused();
    ro_cmd_valid = 1'b1;
    ro_cmd = START;
    for (int i = 0; i < START_REFUSE_CYCLES; i++) begin
      @(negedge adc_clk);
      check_ready(ro_cmd_ready, 1'b0, "START refused before capture is done");
      next_cycle();
    end
    ro_cmd_valid = 1'b0;
  endtask

  // full-rate samples, so a capture that was still armed would fill and report
  task automatic check_no_report(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      drive_samples(100);
      @(negedge adc_clk);
      check_ready(write_depth_valid, 1'b0, "no write-depth report expected");
      next_cycle();
    end
    adc_data = '0;
  endtask

  task automatic run_capture(input int valid_pct);
    int cycles;
    cycles = 0;
    while (model_armed && cycles < CAPTURE_TIMEOUT) begin
      drive_samples(valid_pct);
      next_cycle();
      cycles++;
    end
    adc_data = '0;
    if (model_armed) begin
      report_timeout("capture never filled a final bank");
    end
  endtask

  task automatic collect_report(input int hold_cycles);
    write_depth_t want;
    int waited;
    want = expected_depth();
    waited = 0;
    @(negedge adc_clk);
    while (!write_depth_valid && waited < WAIT_TIMEOUT) begin
      next_cycle();
      @(negedge adc_clk);
      waited++;
    end
    if (!write_depth_valid) begin
      report_timeout("no write-depth report after capture");
      return;
    end
    check_depth(write_depth, want, "write-depth report");
    // report must stay put while ready is low
    for (int i = 0; i < hold_cycles; i++) begin
      next_cycle();
      @(negedge adc_clk);
      check_ready(write_depth_valid, 1'b1, "report held under back-pressure");
      check_depth(write_depth, want, "held write-depth report");
    end
    next_cycle();
    write_depth_ready = 1'b1;
    next_cycle();
    write_depth_ready = 1'b0;
    @(negedge adc_clk);
    check_ready(write_depth_valid, 1'b0, "one report per capture");
    next_cycle();
  endtask

  task automatic run_readout(input bit backpressure, input int stop_after);
    readout_word_t want;
    int idx;
    int bank;
    int slot;
    int waited;
    idx = 0;
    waited = 0;
    send_ro_cmd(START);
    while (!timed_out && idx < stop_after && waited < WAIT_TIMEOUT) begin
      readout_ready = backpressure ? ($urandom_range(3, 0) != 0) : 1'b1;
      @(negedge adc_clk);
      // the readout is busy at least until its final word is on the output
      if (!(readout_valid && readout.last)) begin
        check_ready(cap_cmd_ready, 1'b0, "capture command held off during readout");
      end
      if (readout_valid && readout_ready) begin
        bank = idx / BUFFER_DEPTH;
        slot = idx % BUFFER_DEPTH;
        want.data = exp_mem[bank][slot];
        want.last = idx == WORDS - 1;
        check_word(readout, want, exp_written[bank][slot], $sformatf("readout word %0d", idx));
        idx++;
        waited = 0;
      end else begin
        waited++;
      end
      next_cycle();
    end
    readout_ready = 1'b0;
    if (!timed_out && idx < stop_after) begin
      report_timeout("readout stream stalled");
    end
  endtask

  task automatic check_stream_idle(input string what);
    readout_ready = 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge adc_clk);
      check_ready(readout_valid, 1'b0, what);
      check_ready(write_depth_valid, 1'b0, "no extra write-depth report");
      next_cycle();
    end
    readout_ready = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  task automatic run_test(input int t);
    test_row_t row;
    int errors_before;
    row = rows[t];
    errors_before = errors;
    if (row.abort_kind == ABORT_CAPTURE) begin
      arm_capture(row.mode);
      for (int i = 0; i < 8; i++) begin
        drive_samples(100);
        next_cycle();
      end
      adc_data = '0;
      send_cap_cmd(CAPTURE_RESET, row.mode);
      model_armed = 1'b0;
      check_no_report(WORDS + 8);
      check_start_refused();
    end
    if (!timed_out) arm_capture(row.mode);
    if (!timed_out) check_start_refused();
    if (!timed_out) run_capture(row.valid_pct);
    if (!timed_out) collect_report(row.depth_hold);
    if (!timed_out && row.abort_kind == ABORT_READOUT) begin
      run_readout(row.backpressure, 20);
      send_ro_cmd(READOUT_RESET);
      check_stream_idle("stream stopped by READOUT_RESET");
    end
    if (!timed_out) run_readout(row.backpressure, WORDS);
    if (!timed_out) check_stream_idle("no word after the last one");
    if (errors == errors_before && !timed_out) begin
      tests_passed++;
      $display("test %0d mode %0d valid %0d%%: ok", t, row.mode, row.valid_pct);
    end else begin
      tests_failed++;
      $display("test %0d mode %0d valid %0d%%: failed", t, row.mode, row.valid_pct);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    model_armed = 1'b0;
    active = 1;
    reset = 1'b1;
    adc_data = '0;
    cap_cmd_valid = 1'b0;
    cap_cmd = '{op: ARM, mode: 2'd0};
    ro_cmd_valid = 1'b0;
    ro_cmd = START;
    write_depth_ready = 1'b0;
    readout_ready = 1'b0;
    repeat (10) @(posedge adc_clk);
    #1;
    reset = 1'b0;
    @(negedge adc_clk);
    check_ready(write_depth_valid, 1'b0, "no report after reset");
    check_ready(readout_valid, 1'b0, "no readout word after reset");
    next_cycle();
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t);
    end
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/adc_buffer.sv
/*
 * ADC capture buffer: banked capture, write-depth report and bank readout.
 * Single clock. BUFFER_DEPTH must equal buffer_pkg::BUFFER_DEPTH.
 */
`timescale 1ns/1ps
`default_nettype none

module adc_buffer #(
  parameter int BUFFER_DEPTH = buffer_pkg::BUFFER_DEPTH
) (
  input  logic                      adc_clk,
  input  logic                      reset_i,

  input  rx_pkg::adc_data_t         adc_data_i,

  input  logic                      cap_cmd_valid_i,
  input  buffer_pkg::cap_cmd_t      cap_cmd_i,
  output logic                      cap_cmd_ready_o,

  input  logic                      ro_cmd_valid_i,
  input  buffer_pkg::ro_op_t        ro_cmd_i,
  output logic                      ro_cmd_ready_o,

  output logic                      write_depth_valid_o,
  output buffer_pkg::write_depth_t  write_depth_o,
  input  logic                      write_depth_ready_i,

  output logic                      readout_valid_o,
  output buffer_pkg::readout_word_t readout_o,
  input  logic                      readout_ready_i
);

  import rx_pkg::*;
  import buffer_pkg::*;

  localparam int ADDR_W = $clog2(BUFFER_DEPTH);

  logic [CHANNELS-1:0]             bank_wr_en;
  logic [CHANNELS-1:0][ADDR_W-1:0] bank_wr_addr;
  sample_t [CHANNELS-1:0]          bank_wr_data;
  sample_t [CHANNELS-1:0]          bank_rd_data;
  logic                            rd_en;
  logic [ADDR_W-1:0]               rd_addr;
  logic                            capture_done;
  logic                            readout_busy;
  logic                            depth_valid;
  write_depth_t                    depth;
  logic                            ro_word_valid;
  readout_word_t                   ro_word;
  logic                            ro_word_ready;
  logic                            cap_flush;
  logic                            ro_flush;

  // accepted resets also clear the output registers
  assign cap_flush = cap_cmd_valid_i & cap_cmd_ready_o & (cap_cmd_i.op == CAPTURE_RESET);
  assign ro_flush = ro_cmd_valid_i & ro_cmd_ready_o & (ro_cmd_i == READOUT_RESET);

  capture_control #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) capture_control_i (
    .adc_clk,
    .reset_i,
    .adc_data_i,
    .cap_cmd_valid_i,
    .cap_cmd_i,
    .cap_cmd_ready_o,
    .readout_busy_i(readout_busy),
    .bank_wr_en_o(bank_wr_en),
    .bank_wr_addr_o(bank_wr_addr),
    .bank_wr_data_o(bank_wr_data),
    .capture_done_o(capture_done),
    .depth_valid_o(depth_valid),
    .depth_o(depth)
  );

  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    capture_bank #(
      .BUFFER_DEPTH(BUFFER_DEPTH)
    ) bank_i (
      .adc_clk,
      .wr_en_i(bank_wr_en[b]),
      .wr_addr_i(bank_wr_addr[b]),
      .wr_data_i(bank_wr_data[b]),
      .rd_en_i(rd_en),
      .rd_addr_i(rd_addr),
      .rd_data_o(bank_rd_data[b])
    );
  end

  readout_control #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) readout_control_i (
    .adc_clk,
    .reset_i,
    .ro_cmd_valid_i,
    .ro_cmd_i,
    .ro_cmd_ready_o,
    .capture_done_i(capture_done),
    .readout_busy_o(readout_busy),
    .rd_en_o(rd_en),
    .rd_addr_o(rd_addr),
    .bank_rd_data_i(bank_rd_data),
    .out_valid_o(ro_word_valid),
    .out_o(ro_word),
    .out_ready_i(ro_word_ready)
  );

  // one report per capture, so the entry is never overwritten
  stream_reg #(
    .T(write_depth_t)
  ) depth_reg_i (
    .adc_clk,
    .reset_i,
    .flush_i(cap_flush),
    .in_valid_i(depth_valid),
    .in_i(depth),
    .in_ready_o(),
    .out_valid_o(write_depth_valid_o),
    .out_o(write_depth_o),
    .out_ready_i(write_depth_ready_i)
  );

  stream_reg #(
    .T(readout_word_t)
  ) readout_reg_i (
    .adc_clk,
    .reset_i,
    .flush_i(ro_flush),
    .in_valid_i(ro_word_valid),
    .in_i(ro_word),
    .in_ready_o(ro_word_ready),
    .out_valid_o(readout_valid_o),
    .out_o(readout_o),
    .out_ready_i(readout_ready_i)
  );

endmodule

`default_nettype wire

//--- rtl/stream_reg.sv
/*
 * One-entry valid/ready register, full throughput.
 * flush_i drops a held entry regardless of the downstream side.
 */
`timescale 1ns/1ps
`default_nettype none

module stream_reg #(
  parameter type T = logic
) (
  input  logic adc_clk,
  input  logic reset_i,
  input  logic flush_i,

  input  logic in_valid_i,
  input  T     in_i,
  output logic in_ready_o,

  output logic out_valid_o,
  output T     out_o,
  input  logic out_ready_i
);

  // refill in the same cycle the entry is taken
  assign in_ready_o = !out_valid_o | out_ready_i;

  always_ff @(posedge adc_clk) begin
    if (reset_i || flush_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (in_valid_i && in_ready_o) begin
      out_o <= in_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/readout_control.sv
/*
 * Walks every bank in order, BUFFER_DEPTH words each, written or not.
 * Busy ends once the final word moves into the output register.
 */
`timescale 1ns/1ps
`default_nettype none

module readout_control #(
  parameter int BUFFER_DEPTH = 16
) (
  input  logic                                   adc_clk,
  input  logic                                   reset_i,

  input  logic                                   ro_cmd_valid_i,
  input  buffer_pkg::ro_op_t                     ro_cmd_i,
  output logic                                   ro_cmd_ready_o,
  input  logic                                   capture_done_i,
  output logic                                   readout_busy_o,

  output logic                                   rd_en_o,
  output logic [$clog2(BUFFER_DEPTH)-1:0]        rd_addr_o,
  input  rx_pkg::sample_t [rx_pkg::CHANNELS-1:0] bank_rd_data_i,

  output logic                                   out_valid_o,
  output buffer_pkg::readout_word_t              out_o,
  input  logic                                   out_ready_i
);

  import rx_pkg::*;
  import buffer_pkg::*;

  localparam int ADDR_W = $clog2(BUFFER_DEPTH);
  localparam int BANK_W = $clog2(CHANNELS);
  localparam int CNT_W = ADDR_W + BANK_W;

  logic              busy_q;
  logic              issued_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              p_valid_q;
  logic              p_last_q;
  logic [BANK_W-1:0] p_bank_q;
  logic              cmd_fire;
  logic              issuing;
  logic              advance;

  // reset is always taken, start only after a finished capture
  assign ro_cmd_ready_o = (ro_cmd_i == READOUT_RESET) | (capture_done_i & !busy_q);
  assign cmd_fire = ro_cmd_valid_i & ro_cmd_ready_o;

  assign issuing = busy_q & !issued_q;
  // read stage moves only when its word can leave
  assign advance = !p_valid_q | out_ready_i;
  assign rd_en_o = advance & issuing;

  // upper counter bits pick the bank, lower bits the address
  assign rd_addr_o = cnt_q[ADDR_W-1:0];
  assign readout_busy_o = busy_q;

  assign out_valid_o = p_valid_q;
  assign out_o = '{data: bank_rd_data_i[p_bank_q], last: p_last_q};

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      issued_q <= 1'b0;
      cnt_q <= '0;
      p_valid_q <= 1'b0;
      p_last_q <= 1'b0;
    end else if (cmd_fire) begin
      busy_q <= ro_cmd_i == START;
      issued_q <= 1'b0;
      cnt_q <= '0;
      p_valid_q <= 1'b0;
      p_last_q <= 1'b0;
    end else if (advance) begin
      p_valid_q <= issuing;
      p_last_q <= issuing & (&cnt_q);
      if (issuing) begin
        cnt_q <= cnt_q + 1'b1;
        if (&cnt_q) begin
          issued_q <= 1'b1;
        end
      end
      // final word handed on
      if (p_valid_q & p_last_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (advance) begin
      p_bank_q <= cnt_q[CNT_W-1:ADDR_W];
    end
  end

endmodule

`default_nettype wire

//--- rtl/capture_control.sv
/*
 * Arms capture, routes each active channel to its banks and tracks fill depth.
 * BUFFER_DEPTH must be a power of two. The report pulses for one cycle only
 * when a channel fills its last bank; there is no report for a partial capture.
 */
`timescale 1ns/1ps
`default_nettype none

module capture_control #(
  parameter int BUFFER_DEPTH = 16
) (
  input  logic                                                 adc_clk,
  input  logic                                                 reset_i,

  input  rx_pkg::adc_data_t                                    adc_data_i,

  input  logic                                                 cap_cmd_valid_i,
  input  buffer_pkg::cap_cmd_t                                 cap_cmd_i,
  output logic                                                 cap_cmd_ready_o,
  input  logic                                                 readout_busy_i,

  output logic [rx_pkg::CHANNELS-1:0]                          bank_wr_en_o,
  output logic [rx_pkg::CHANNELS-1:0][$clog2(BUFFER_DEPTH)-1:0] bank_wr_addr_o,
  output rx_pkg::sample_t [rx_pkg::CHANNELS-1:0]               bank_wr_data_o,

  output logic                                                 capture_done_o,
  output logic                                                 depth_valid_o,
  output buffer_pkg::write_depth_t                             depth_o
);

  import rx_pkg::*;
  import buffer_pkg::*;

  localparam int ADDR_W = $clog2(BUFFER_DEPTH);
  localparam int BANK_W = $clog2(CHANNELS);
  localparam logic [ADDR_W-1:0] LAST_SLOT = ADDR_W'(BUFFER_DEPTH - 1);

  logic                             armed_q;
  logic                             done_q;
  banking_mode_t                    mode_q;
  logic [BANK_W:0]                  active_cnt;
  logic [CHANNELS-1:0][BANK_W-1:0]  cur_bank_q;
  logic [CHANNELS-1:0][ADDR_W-1:0]  fill_q;
  logic [CHANNELS-1:0]              ch_wr;
  logic [CHANNELS-1:0]              ch_last_slot;
  logic [CHANNELS-1:0]              ch_last_bank;
  write_depth_t                     depth_q;
  write_depth_t                     depth_next;
  logic                             cmd_fire;
  logic                             stop;

  // commands are held off while a readout walks the banks
  assign cap_cmd_ready_o = !readout_busy_i;
  assign cmd_fire = cap_cmd_valid_i & cap_cmd_ready_o;
  assign active_cnt = (BANK_W+1)'(1) << mode_q;

  //////////////////////////////////////////////////
  // per-channel fill state
  //////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      ch_wr[c] = armed_q & adc_data_i.valid[c] & (c < int'(active_cnt));
      ch_last_slot[c] = fill_q[c] == LAST_SLOT;
      ch_last_bank[c] = int'(cur_bank_q[c]) + int'(active_cnt) >= CHANNELS;
    end
  end

  // other channels still write on the stopping edge
  assign stop = |(ch_wr & ch_last_slot & ch_last_bank);

  //////////////////////////////////////////////////
  // bank routing and depth tracking
  //////////////////////////////////////////////////

  always_comb begin
    int owner;
    depth_next = depth_q;
    for (int b = 0; b < CHANNELS; b++) begin
      // bank b belongs to channel b mod active count
      owner = b % int'(active_cnt);
      bank_wr_en_o[b] = ch_wr[owner] & (int'(cur_bank_q[owner]) == b);
      bank_wr_addr_o[b] = fill_q[owner];
      bank_wr_data_o[b] = adc_data_i.data[owner];
      if (bank_wr_en_o[b]) begin
        depth_next[b].full = ch_last_slot[owner];
        depth_next[b].count = fill_q[owner] + 1'b1;
      end
    end
  end

  // report includes the writes of the stopping edge
  assign depth_o = depth_next;
  assign depth_valid_o = stop & !cmd_fire;
  assign capture_done_o = done_q;

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      armed_q <= 1'b0;
      done_q <= 1'b0;
      mode_q <= '0;
      cur_bank_q <= '0;
      fill_q <= '0;
      depth_q <= '0;
    end else if (cmd_fire) begin
      armed_q <= cap_cmd_i.op == ARM;
      done_q <= 1'b0;
      if (cap_cmd_i.op == ARM) begin
        mode_q <= (cap_cmd_i.mode == 2'd3) ? 2'd2 : cap_cmd_i.mode;
        fill_q <= '0;
        depth_q <= '0;
        for (int c = 0; c < CHANNELS; c++) begin
          cur_bank_q[c] <= BANK_W'(c);
        end
      end
    end else begin
      depth_q <= depth_next;
      if (stop) begin
        armed_q <= 1'b0;
        done_q <= 1'b1;
      end
      for (int c = 0; c < CHANNELS; c++) begin
        if (ch_wr[c]) begin
          // wraps to zero on the last slot
          fill_q[c] <= fill_q[c] + 1'b1;
          if (ch_last_slot[c]) begin
            cur_bank_q[c] <= cur_bank_q[c] + active_cnt[BANK_W-1:0];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/capture_bank.sv
/*
 * Simple dual-port sample memory with a registered read.
 * rd_en_i low holds the read output, which lets the readout stall.
 */
`timescale 1ns/1ps
`default_nettype none

module capture_bank #(
  parameter int BUFFER_DEPTH = 16
) (
  input  logic                            adc_clk,

  input  logic                            wr_en_i,
  input  logic [$clog2(BUFFER_DEPTH)-1:0] wr_addr_i,
  input  rx_pkg::sample_t                 wr_data_i,

  input  logic                            rd_en_i,
  input  logic [$clog2(BUFFER_DEPTH)-1:0] rd_addr_i,
  output rx_pkg::sample_t                 rd_data_o
);

  rx_pkg::sample_t mem [BUFFER_DEPTH];

  always_ff @(posedge adc_clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // one cycle read latency
  always_ff @(posedge adc_clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

//--- rtl/buffer_pkg.sv
/*
 * Buffer-side types: banking mode, commands, write-depth report, readout word.
 * The report is sized from BUFFER_DEPTH here, so the top-level depth must match.
 */
`default_nettype none

package buffer_pkg;

  localparam int BUFFER_DEPTH = 16;
  localparam int BANKING_MODE_WIDTH = 2;

  // active channels = 1 << mode, mode 3 behaves as mode 2
  typedef logic [BANKING_MODE_WIDTH-1:0] banking_mode_t;

  typedef enum logic {
    ARM,
    CAPTURE_RESET
  } cap_op_t;

  // mode is only looked at together with ARM
  typedef struct packed {
    cap_op_t       op;
    banking_mode_t mode;
  } cap_cmd_t;

  typedef enum logic {
    START,
    READOUT_RESET
  } ro_op_t;

  // a full bank reports full=1 with the count wrapped to zero
  typedef struct packed {
    logic                            full;
    logic [$clog2(BUFFER_DEPTH)-1:0] count;
  } bank_depth_t;

  typedef bank_depth_t [rx_pkg::CHANNELS-1:0] write_depth_t;

  typedef struct packed {
    rx_pkg::sample_t data;
    logic            last;
  } readout_word_t;

endpackage

`default_nettype wire

//--- rtl/rx_pkg.sv
/*
 * ADC-side constants and sample types, shared by capture and readout.
 * CHANNELS must be a power of two and at least 4 for the banking logic.
 */
`default_nettype none

package rx_pkg;

  // parallel ADC lanes, one bank per lane
  localparam int CHANNELS = 4;
  localparam int DATA_WIDTH = 16;

  typedef logic [DATA_WIDTH-1:0] sample_t;

  // realtime input, no back-pressure
  typedef struct packed {
    logic [CHANNELS-1:0]    valid;
    sample_t [CHANNELS-1:0] data;
  } adc_data_t;

endpackage

`default_nettype wire
